//--- RISCV_TOP.sv
`default_nettype none
`include "riscv_config.svh"

module RISCV_TOP (
	input logic CLK,
	input logic RSTn,

	output logic I_MEM_CSN,
	input logic [`XLEN-1:0] I_MEM_DI,
	output logic [`IADDR_W-1:0] I_MEM_ADDR, // byte address

	output logic D_MEM_CSN,
	input logic [`XLEN-1:0] D_MEM_DI,
	output logic [`XLEN-1:0] D_MEM_DOUT,
	output logic [`DADDR_W-1:0] D_MEM_ADDR, // word address
	output logic D_MEM_WEN,
	output logic [3:0] D_MEM_BE,

	output logic RF_WE,
	output logic [`REG_W-1:0] RF_RA1,
	output logic [`REG_W-1:0] RF_RA2,
	output logic [`REG_W-1:0] RF_WA1,
	input logic [`XLEN-1:0] RF_RD1,
	input logic [`XLEN-1:0] RF_RD2,
	output logic [`XLEN-1:0] RF_WD,
	output logic HALT,
	output logic [`XLEN-1:0] NUM_INST,
	output logic [`XLEN-1:0] OUTPUT_PORT
);

	logic [`XLEN-1:0] pc, pcPlus4, branchTarget, jumpTarget;
	logic [`XLEN-1:0] aluA, aluB, aluY, loadData;
	logic aluZero, aluLt, aluLtu, branchTaken;

	ctrlIf ctrl (.CLK(CLK));

	pcUnit pcUnit0 (.CLK(CLK), .RSTn(RSTn), .ctrl(ctrl), .branchTaken(branchTaken),
		.jumpTarget(jumpTarget), .pc(pc));

	instrDecoder decoder0 (.RSTn(RSTn), .instr(I_MEM_DI), .ctrl(ctrl),
		.ra1(RF_RA1), .ra2(RF_RA2), .wa(RF_WA1));

	assign aluA = ctrl.aluSrcPc ? pc : RF_RD1;
	assign aluB = ctrl.aluSrcImm ? ctrl.imm : RF_RD2;

	alu alu0 (.op(ctrl.aluOp), .a(aluA), .b(aluB), .y(aluY),
		.zero(aluZero), .lt(aluLt), .ltu(aluLtu));

	branchCompare branch0 (.ctrl(ctrl), .zero(aluZero), .lt(aluLt), .ltu(aluLtu),
		.taken(branchTaken));

	loadStoreUnit lsu0 (.ctrl(ctrl), .addrLow(aluY[1:0]), .storeData(RF_RD2),
		.memRdata(D_MEM_DI), .be(D_MEM_BE), .memWdata(D_MEM_DOUT), .loadData(loadData));

	// alu is busy comparing on branches, so the target gets its own adder
	assign branchTarget = pc + ctrl.imm;
	assign jumpTarget = ctrl.isBranch ? branchTarget : aluY;
	assign pcPlus4 = pc + `XLEN'(4);

	assign I_MEM_ADDR = pc[`IADDR_W-1:0];
	assign I_MEM_CSN = RSTn; // fetch idle in reset
	assign D_MEM_ADDR = aluY[`DADDR_W+1:2];
	assign D_MEM_CSN = !(ctrl.memRead || ctrl.memWrite);
	assign D_MEM_WEN = !ctrl.memWrite;
	assign RF_WE = ctrl.rfWe;
	assign HALT = ctrl.halt;

	always_comb begin
		case (ctrl.wbSel)
			riscvPkg::WB_LOAD: RF_WD = loadData;
			riscvPkg::WB_PCPLUS4: RF_WD = pcPlus4; // jal/jalr link
			default: RF_WD = aluY;
		endcase
	end

	assign OUTPUT_PORT = RF_WD;

	// retired instruction count, ebreak itself not counted
	always_ff @(posedge CLK) begin
		if (RSTn)
			NUM_INST <= '0;
		else if (!ctrl.halt)
			NUM_INST <= NUM_INST + `XLEN'(1);
	end

endmodule

`default_nettype wire

//--- alu.sv
`default_nettype none
`include "riscv_config.svh"

module alu (
	input riscvPkg::aluOpT op,
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	output logic [`XLEN-1:0] y,
	output logic zero,
	output logic lt,
	output logic ltu
);

	logic [4:0] shamt;

	assign shamt = b[4:0];
	assign lt = $signed(a) < $signed(b);
	assign ltu = a < b;
	assign zero = (y == '0); // equality for branches via sub

	always_comb begin
		case (op)
			riscvPkg::ALU_ADD: y = a + b;
			riscvPkg::ALU_SUB: y = a - b;
			riscvPkg::ALU_SLL: y = a << shamt;
			riscvPkg::ALU_SLT: y = {{(`XLEN-1){1'b0}}, lt};
			riscvPkg::ALU_SLTU: y = {{(`XLEN-1){1'b0}}, ltu};
			riscvPkg::ALU_XOR: y = a ^ b;
			riscvPkg::ALU_SRL: y = a >> shamt;
			riscvPkg::ALU_SRA: y = $unsigned($signed(a) >>> shamt);
			riscvPkg::ALU_OR: y = a | b;
			riscvPkg::ALU_AND: y = a & b;
			riscvPkg::ALU_PASSB: y = b;
			default: y = a + b;
		endcase
	end

endmodule

`default_nettype wire

//--- branchCompare.sv
`default_nettype none

module branchCompare (
	ctrlIf.datapath ctrl,
	input logic zero,
	input logic lt,
	input logic ltu,
	output logic taken
);

	logic cond;

	// flags come from rs1 - rs2
	always_comb begin
		case (ctrl.funct3)
			3'b000: cond = zero; // beq
			3'b001: cond = !zero; // bne
			3'b100: cond = lt; // blt
			3'b101: cond = !lt; // bge
			3'b110: cond = ltu; // bltu
			3'b111: cond = !ltu; // bgeu
			default: cond = 1'b0;
		endcase
	end

	assign taken = ctrl.isBranch && cond;

endmodule

`default_nettype wire

//--- ctrlIf.sv
`default_nettype none
`include "riscv_config.svh"

interface ctrlIf (input logic CLK);
	riscvPkg::aluOpT aluOp;
	logic aluSrcPc; // operand a from pc
	logic aluSrcImm; // operand b from imm
	logic [`XLEN-1:0] imm;
	riscvPkg::wbSelT wbSel;
	logic rfWe;
	logic memRead;
	logic memWrite;
	riscvPkg::memSizeT memSize;
	logic memUnsigned;
	logic isBranch;
	logic isJal;
	logic isJalr;
	logic [2:0] funct3;
	logic halt;

	modport decoder (input CLK, output aluOp, aluSrcPc, aluSrcImm, imm, wbSel, rfWe,
		memRead, memWrite, memSize, memUnsigned, isBranch, isJal, isJalr, funct3, halt);

	modport datapath (input CLK, aluOp, aluSrcPc, aluSrcImm, imm, wbSel, rfWe,
		memRead, memWrite, memSize, memUnsigned, isBranch, isJal, isJalr, funct3, halt);
endinterface

`default_nettype wire

//--- instrDecoder.sv
`default_nettype none
`include "riscv_config.svh"

module instrDecoder (
	input logic RSTn,
	input logic [`XLEN-1:0] instr,
	ctrlIf.decoder ctrl,
	output logic [`REG_W-1:0] ra1,
	output logic [`REG_W-1:0] ra2,
	output logic [`REG_W-1:0] wa
);

	riscvPkg::opcodeT opcode;
	riscvPkg::aluOpT arithOp;
	logic [`XLEN-1:0] immI, immS, immB, immU, immJ;

	assign ra1 = instr[19:15];
	assign ra2 = instr[24:20];
	assign wa = instr[11:7];

	assign opcode = riscvPkg::opcodeT'(instr[6:0]);

	// immediate formats
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// funct3/funct7 onto alu op, shared by op and op-imm
	always_comb begin
		case (instr[14:12])
			3'b000: arithOp = (opcode == riscvPkg::OP_OP && instr[30]) ?
				riscvPkg::ALU_SUB : riscvPkg::ALU_ADD; // no subi
			3'b001: arithOp = riscvPkg::ALU_SLL;
			3'b010: arithOp = riscvPkg::ALU_SLT;
			3'b011: arithOp = riscvPkg::ALU_SLTU;
			3'b100: arithOp = riscvPkg::ALU_XOR;
			3'b101: arithOp = instr[30] ? riscvPkg::ALU_SRA : riscvPkg::ALU_SRL;
			3'b110: arithOp = riscvPkg::ALU_OR;
			default: arithOp = riscvPkg::ALU_AND;
		endcase
	end

	always_comb begin
		ctrl.aluOp = riscvPkg::ALU_ADD;
		ctrl.aluSrcPc = 1'b0;
		ctrl.aluSrcImm = 1'b0;
		ctrl.imm = '0;
		ctrl.wbSel = riscvPkg::WB_ALU;
		ctrl.rfWe = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memSize = riscvPkg::memSizeT'(instr[13:12]);
		ctrl.memUnsigned = instr[14];
		ctrl.isBranch = 1'b0;
		ctrl.isJal = 1'b0;
		ctrl.isJalr = 1'b0;
		ctrl.funct3 = instr[14:12];
		ctrl.halt = 1'b0;

		case (opcode)
			riscvPkg::OP_LUI: begin
				ctrl.imm = immU;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = riscvPkg::ALU_PASSB;
				ctrl.rfWe = 1'b1;
			end
			riscvPkg::OP_AUIPC: begin
				ctrl.imm = immU;
				ctrl.aluSrcPc = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.rfWe = 1'b1;
			end
			riscvPkg::OP_JAL: begin
				ctrl.imm = immJ;
				ctrl.aluSrcPc = 1'b1; // target = pc + imm
				ctrl.aluSrcImm = 1'b1;
				ctrl.isJal = 1'b1;
				ctrl.wbSel = riscvPkg::WB_PCPLUS4;
				ctrl.rfWe = 1'b1;
			end
			riscvPkg::OP_JALR: begin
				ctrl.imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.isJalr = 1'b1;
				ctrl.wbSel = riscvPkg::WB_PCPLUS4;
				ctrl.rfWe = 1'b1;
			end
			riscvPkg::OP_BRANCH: begin
				ctrl.imm = immB; // target comes from the separate adder
				ctrl.aluOp = riscvPkg::ALU_SUB;
				ctrl.isBranch = 1'b1;
			end
			riscvPkg::OP_LOAD: begin
				ctrl.imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.wbSel = riscvPkg::WB_LOAD;
				ctrl.rfWe = 1'b1;
			end
			riscvPkg::OP_STORE: begin
				ctrl.imm = immS;
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			riscvPkg::OP_OPIMM: begin
				ctrl.imm = immI;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = arithOp;
				ctrl.rfWe = 1'b1;
			end
			riscvPkg::OP_OP: begin
				ctrl.aluOp = arithOp;
				ctrl.rfWe = 1'b1;
			end
			riscvPkg::OP_SYSTEM: ctrl.halt = (instr == `HALT_INSTR); // ecall etc. act as nop
			default: ;
		endcase

		// nothing may be written while reset is held
		if (RSTn) begin
			ctrl.rfWe = 1'b0;
			ctrl.memRead = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.halt = 1'b0;
		end
	end

	// single memory port, one direction per cycle
	memOneWay: assert property (@(posedge ctrl.CLK) !(ctrl.memRead && ctrl.memWrite));

endmodule

`default_nettype wire

//--- loadStoreUnit.sv
`default_nettype none
`include "riscv_config.svh"

module loadStoreUnit (
	ctrlIf.datapath ctrl,
	input logic [1:0] addrLow,
	input logic [`XLEN-1:0] storeData,
	input logic [`XLEN-1:0] memRdata,
	output logic [3:0] be,
	output logic [`XLEN-1:0] memWdata,
	output logic [`XLEN-1:0] loadData
);

	logic [7:0] ldByte;
	logic [15:0] ldHalf;

	// store side, data copied into every lane, be picks the lane
	always_comb begin
		case (ctrl.memSize)
			riscvPkg::MEM_BYTE: begin
				be = 4'b0001 << addrLow;
				memWdata = {4{storeData[7:0]}};
			end
			riscvPkg::MEM_HALF: begin
				be = addrLow[1] ? 4'b1100 : 4'b0011;
				memWdata = {2{storeData[15:0]}};
			end
			default: begin
				be = 4'b1111;
				memWdata = storeData;
			end
		endcase
		if (!(ctrl.memRead || ctrl.memWrite))
			be = 4'b0000;
	end

	// load side
	assign ldByte = memRdata[{addrLow, 3'b000} +: 8];
	assign ldHalf = addrLow[1] ? memRdata[31:16] : memRdata[15:0];

	always_comb begin
		case (ctrl.memSize)
			riscvPkg::MEM_BYTE: loadData = {{24{ldByte[7] & !ctrl.memUnsigned}}, ldByte};
			riscvPkg::MEM_HALF: loadData = {{16{ldHalf[15] & !ctrl.memUnsigned}}, ldHalf};
			default: loadData = memRdata;
		endcase
	end

	// no misalignment traps, the program must keep accesses aligned
	halfAligned: assert property (@(posedge ctrl.CLK)
		(ctrl.memRead || ctrl.memWrite) && ctrl.memSize == riscvPkg::MEM_HALF |-> !addrLow[0]);
	wordAligned: assert property (@(posedge ctrl.CLK)
		(ctrl.memRead || ctrl.memWrite) && ctrl.memSize == riscvPkg::MEM_WORD |-> addrLow == 2'b00);

endmodule

`default_nettype wire

//--- pcUnit.sv
`default_nettype none
`include "riscv_config.svh"

module pcUnit (
	input logic CLK,
	input logic RSTn,
	ctrlIf.datapath ctrl,
	input logic branchTaken,
	input logic [`XLEN-1:0] jumpTarget,
	output logic [`XLEN-1:0] pc
);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
		end else if (!ctrl.halt) begin
			if (branchTaken || ctrl.isJal) begin
				pc <= jumpTarget;
			end else if (ctrl.isJalr) begin
				pc <= {jumpTarget[`XLEN-1:1], 1'b0}; // jalr drops bit 0
			end else begin
				pc <= pc + `XLEN'(4);
			end
		end
	end

	// fetch stays word aligned, jump and branch targets included
	pcAligned: assert property (@(posedge CLK) disable iff (RSTn)
		pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- project.f
+incdir+.
riscvPkg.sv
ctrlIf.sv
pcUnit.sv
instrDecoder.sv
alu.sv
branchCompare.sv
loadStoreUnit.sv
RISCV_TOP.sv
tbMemRf.sv
tbRiscv.sv

//--- riscvPkg.sv
`default_nettype none

package riscvPkg;

	// major opcodes of rv32i
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_OPIMM  = 7'b0010011,
		OP_OP     = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcodeT;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASSB // lui
	} aluOpT;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_PCPLUS4
	} wbSelT;

	// same order as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD
	} memSizeT;

endpackage

`default_nettype wire

//--- riscv_config.svh
`ifndef RISCV_CONFIG_SVH
`define RISCV_CONFIG_SVH

// datapath width
`define XLEN 32

// instruction memory byte address
`define IADDR_W 12

// data memory word address
`define DADDR_W 12

// register index
`define REG_W 5

// ebreak stops the core
`define HALT_INSTR 32'h0010_0073

`endif

//--- run.sh
#!/bin/sh
# build and run the RV32I core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module tbRiscv

./obj_dir/VtbRiscv 2>&1 | tee sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- tbMemRf.sv
`default_nettype none
`include "riscv_config.svh"

module tbMemRf (
	input logic CLK,
	input logic iMemCsn,
	input logic [`IADDR_W-1:0] iMemAddr,
	output logic [`XLEN-1:0] iMemDi,
	input logic dMemCsn,
	input logic dMemWen,
	input logic [3:0] dMemBe,
	input logic [`DADDR_W-1:0] dMemAddr,
	input logic [`XLEN-1:0] dMemDout,
	output logic [`XLEN-1:0] dMemDi,
	input logic rfWe,
	input logic [`REG_W-1:0] rfRa1,
	input logic [`REG_W-1:0] rfRa2,
	input logic [`REG_W-1:0] rfWa1,
	input logic [`XLEN-1:0] rfWd,
	output logic [`XLEN-1:0] rfRd1,
	output logic [`XLEN-1:0] rfRd2
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [`XLEN-1:0] rom [1 << (`IADDR_W - 2)]; // program written by tbRiscv
	logic [`XLEN-1:0] ram [1 << `DADDR_W];
	logic [`XLEN-1:0] regs [1 << `REG_W];

	initial begin
		for (int i = 0; i < (1 << `DADDR_W); i++)
			ram[i] = {4'hD, 12'(i), ~12'(i), 4'h5}; // each word tells its own address
		for (int i = 0; i < (1 << `REG_W); i++)
			regs[i] = '0;
	end

	// combinational reads, x0 is hardwired
	assign iMemDi = iMemCsn ? '0 : rom[iMemAddr[`IADDR_W-1:2]];
	assign dMemDi = dMemCsn ? '0 : ram[dMemAddr];
	assign rfRd1 = (rfRa1 == '0) ? '0 : regs[rfRa1];
	assign rfRd2 = (rfRa2 == '0) ? '0 : regs[rfRa2];

	always @(posedge CLK) begin
		logic [`XLEN-1:0] merged;
		merged = ram[dMemAddr];
		for (int i = 0; i < 4; i++)
			if (dMemBe[i])
				merged[8*i +: 8] = dMemDout[8*i +: 8];
		if (!dMemCsn && !dMemWen)
			ram[dMemAddr] <= merged;
		if (rfWe && rfWa1 != '0)
			regs[rfWa1] <= rfWd;
	end

endmodule

`default_nettype wire

//--- tbRiscv.sv
`default_nettype none
`include "riscv_config.svh"

module tbRiscv;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int resetCycles = 16;
	localparam int romWords = 1 << (`IADDR_W - 2);
	localparam logic [6:0] opLui = 7'h37;
	localparam logic [6:0] opAuipc = 7'h17;
	localparam logic [6:0] opJal = 7'h6F;
	localparam logic [6:0] opJalr = 7'h67;
	localparam logic [6:0] opBranch = 7'h63;
	localparam logic [6:0] opLoad = 7'h03;
	localparam logic [6:0] opStore = 7'h23;
	localparam logic [6:0] opImm = 7'h13;
	localparam logic [6:0] opOp = 7'h33;

	logic CLK = 1'b0;
	logic RSTn;
	logic iMemCsn;
	logic [`XLEN-1:0] iMemDi;
	logic [`IADDR_W-1:0] iMemAddr;
	logic dMemCsn;
	logic [`XLEN-1:0] dMemDi;
	logic [`XLEN-1:0] dMemDout;
	logic [`DADDR_W-1:0] dMemAddr;
	logic dMemWen;
	logic [3:0] dMemBe;
	logic rfWe;
	logic [`REG_W-1:0] rfRa1;
	logic [`REG_W-1:0] rfRa2;
	logic [`REG_W-1:0] rfWa1;
	logic [`XLEN-1:0] rfRd1;
	logic [`XLEN-1:0] rfRd2;
	logic [`XLEN-1:0] rfWd;
	logic halt;
	logic [`XLEN-1:0] numInst;
	logic [`XLEN-1:0] outputPort;

	logic [31:0] lcgState;
	logic [31:0] expPc;
	logic [31:0] retired;
	logic haltSeen;
	logic progReady;
	int progLen;

	RISCV_TOP dut0 (
		.CLK(CLK), .RSTn(RSTn),
		.I_MEM_CSN(iMemCsn), .I_MEM_DI(iMemDi), .I_MEM_ADDR(iMemAddr),
		.D_MEM_CSN(dMemCsn), .D_MEM_DI(dMemDi), .D_MEM_DOUT(dMemDout),
		.D_MEM_ADDR(dMemAddr), .D_MEM_WEN(dMemWen), .D_MEM_BE(dMemBe),
		.RF_WE(rfWe), .RF_RA1(rfRa1), .RF_RA2(rfRa2), .RF_WA1(rfWa1),
		.RF_RD1(rfRd1), .RF_RD2(rfRd2), .RF_WD(rfWd),
		.HALT(halt), .NUM_INST(numInst), .OUTPUT_PORT(outputPort)
	);

	tbMemRf mem0 (
		.CLK(CLK), .iMemCsn(iMemCsn), .iMemAddr(iMemAddr), .iMemDi(iMemDi),
		.dMemCsn(dMemCsn), .dMemWen(dMemWen), .dMemBe(dMemBe), .dMemAddr(dMemAddr),
		.dMemDout(dMemDout), .dMemDi(dMemDi), .rfWe(rfWe), .rfRa1(rfRa1),
		.rfRa2(rfRa2), .rfWa1(rfWa1), .rfWd(rfWd), .rfRd1(rfRd1), .rfRd2(rfRd2)
	);

	always #2 CLK = ~CLK;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// instruction encoders
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, opOp};
	endfunction

	function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] encU(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	// rv32i result for lui, auipc, op-imm and op
	function automatic logic [31:0] aluResult(input logic [31:0] ins, a, b, pc);
		logic [31:0] opB;
		logic [4:0] sh;
		if (ins[6:0] == opLui)
			return {ins[31:12], 12'h000};
		if (ins[6:0] == opAuipc)
			return pc + {ins[31:12], 12'h000};
		opB = (ins[6:0] == opImm) ? {{20{ins[31]}}, ins[31:20]} : b;
		sh = opB[4:0];
		case (ins[14:12])
			3'd0: begin
				if (ins[6:0] == opOp && ins[30])
					return a - opB;
				return a + opB;
			end
			3'd1: return a << sh;
			3'd2: return {31'b0, $signed(a) < $signed(opB)};
			3'd3: return {31'b0, a < opB};
			3'd4: return a ^ opB;
			3'd5: begin
				if (ins[30])
					return $signed(a) >>> sh;
				return a >> sh;
			end
			3'd6: return a | opB;
			default: return a & opB;
		endcase
	endfunction

	function automatic logic [31:0] nextPc(input logic [31:0] ins, a, b, pc);
		logic [31:0] immB;
		logic [31:0] immJ;
		logic cond;
		immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		case (ins[14:12])
			3'd0: cond = (a == b);
			3'd1: cond = (a != b);
			3'd4: cond = ($signed(a) < $signed(b));
			3'd5: cond = ($signed(a) >= $signed(b));
			3'd6: cond = (a < b);
			default: cond = (a >= b);
		endcase
		case (ins[6:0])
			opJal: return pc + immJ;
			opJalr: return (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
			opBranch: return cond ? pc + immB : pc + 32'd4;
			default: return pc + 32'd4;
		endcase
	endfunction

	task automatic emit(input logic [31:0] ins);
		mem0.rom[progLen] = ins;
		progLen++;
	endtask

	task automatic emitBranch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		emit(encB(f3, rs1, rs2, 13'd8)); // jumps over the filler when taken
		emit(encI(opImm, 3'd0, 5'd13, 5'd13, 12'd1));
	endtask

	task automatic buildProgram();
		logic [31:0] r;
		for (int i = 0; i < romWords; i++)
			mem0.rom[i] = `HALT_INSTR;
		for (int i = 1; i <= 6; i++) begin
			r = nextRand();
			emit(encU(opLui, 5'(i), r[31:12]));
			emit(encI(opImm, 3'd0, 5'(i), 5'(i), r[11:0]));
		end
		for (int i = 0; i < 8; i++)
			emit(encR(7'h00, 3'(i), 5'd9, 5'(1 + i % 6), 5'(1 + (i + 2) % 6)));
		emit(encR(7'h20, 3'd0, 5'd9, 5'd1, 5'd2)); // sub
		emit(encR(7'h20, 3'd5, 5'd9, 5'd3, 5'd4)); // sra
		for (int i = 0; i < 8; i++) begin
			r = nextRand();
			if (i == 1 || i == 5)
				emit(encI(opImm, 3'(i), 5'd10, 5'(1 + i % 6), {7'h00, r[4:0]}));
			else
				emit(encI(opImm, 3'(i), 5'd10, 5'(1 + i % 6), r[11:0]));
		end
		emit(encI(opImm, 3'd5, 5'd10, 5'd2, {7'h20, 5'd7})); // srai
		r = nextRand();
		emit(encU(opAuipc, 5'd10, r[31:12]));
		// stores then loads around byte 0x100
		emit(encI(opImm, 3'd0, 5'd11, 5'd0, 12'h100));
		emit(encS(3'd2, 5'd11, 5'd1, 12'd0));
		emit(encS(3'd1, 5'd11, 5'd2, 12'd4));
		emit(encS(3'd1, 5'd11, 5'd3, 12'd6));
		for (int i = 0; i < 4; i++)
			emit(encS(3'd0, 5'd11, 5'(4 + i % 3), 12'(8 + i)));
		emit(encI(opLoad, 3'd2, 5'd12, 5'd11, 12'd0));
		emit(encI(opLoad, 3'd1, 5'd12, 5'd11, 12'd4));
		emit(encI(opLoad, 3'd5, 5'd12, 5'd11, 12'd6));
		for (int i = 0; i < 4; i++) begin
			emit(encI(opLoad, 3'd0, 5'd12, 5'd11, 12'(8 + i)));
			emit(encI(opLoad, 3'd4, 5'd12, 5'd11, 12'(8 + i)));
		end
		emit(encI(opLoad, 3'd1, 5'd12, 5'd11, 12'd18)); // untouched words
		emit(encI(opLoad, 3'd5, 5'd12, 5'd11, 12'd22));
		emit(encI(opLoad, 3'd2, 5'd12, 5'd11, 12'd20));
		emitBranch(3'd0, 5'd1, 5'd1); // always taken
		emitBranch(3'd1, 5'd1, 5'd1); // never taken
		emitBranch(3'd4, 5'd1, 5'd2);
		emitBranch(3'd5, 5'd1, 5'd2);
		emitBranch(3'd6, 5'd3, 5'd4);
		emitBranch(3'd7, 5'd3, 5'd4);
		emit(encJ(5'd14, 21'd8));
		emit(encI(opImm, 3'd0, 5'd13, 5'd13, 12'd1));
		emit(encU(opAuipc, 5'd15, 20'd0));
		emit(encI(opJalr, 3'd0, 5'd16, 5'd15, 12'd13)); // odd offset, bit 0 dropped
		emit(encI(opImm, 3'd0, 5'd13, 5'd13, 12'd1));
		emit(`HALT_INSTR);
	endtask

	task automatic reportMismatch(input string what);
		$display("mismatch at %0t ns: %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// all checks sample at the falling edge, between driving edges
	always @(negedge CLK) begin
		logic [31:0] ins, a, b, pc, ea, want, mask;
		logic [3:0] wantBe;
		ins = iMemDi;
		a = rfRd1;
		b = rfRd2;
		pc = 32'(iMemAddr);
		if (RSTn) begin
			assert (iMemAddr == '0 && numInst == '0 && !rfWe && dMemWen && !halt && iMemCsn)
			else reportMismatch($sformatf("reset state pc %h count %0d we %b wen %b halt %b",
				iMemAddr, numInst, rfWe, dMemWen, halt));
			expPc = '0;
			retired = '0;
		end else begin
			assert (pc == expPc)
			else reportMismatch($sformatf("pc %h, expected %h", pc, expPc));
			assert (numInst == retired)
			else reportMismatch($sformatf("NUM_INST %0d, expected %0d", numInst, retired));
			assert (rfRa1 == ins[19:15] && rfRa2 == ins[24:20] && rfWa1 == ins[11:7])
			else reportMismatch($sformatf("register addresses %0d %0d %0d for %h",
				rfRa1, rfRa2, rfWa1, ins));
			expPc = nextPc(ins, a, b, pc);
			if (ins == `HALT_INSTR) begin
				assert (halt && !rfWe && dMemCsn && dMemWen)
				else reportMismatch($sformatf("halt %b we %b at ebreak", halt, rfWe));
				expPc = pc; // pc frozen
				haltSeen = 1'b1;
			end else begin
				assert (!halt) else reportMismatch($sformatf("halt high for %h", ins));
				retired = retired + 32'd1;
				case (ins[6:0])
					opLui, opAuipc, opImm, opOp: begin
						want = aluResult(ins, a, b, pc);
						assert (rfWe && outputPort == want)
						else reportMismatch($sformatf("instr %h result %h we %b, expected %h",
							ins, outputPort, rfWe, want));
					end
					opJal, opJalr: begin
						assert (rfWe && rfWd == pc + 32'd4)
						else reportMismatch($sformatf("link %h, expected %h", rfWd, pc + 32'd4));
					end
					opStore: begin
						ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
						case (ins[13:12])
							2'd0: wantBe = 4'b0001 << ea[1:0];
							2'd1: wantBe = 4'b0011 << ea[1:0];
							default: wantBe = 4'b1111;
						endcase
						mask = {{8{wantBe[3]}}, {8{wantBe[2]}}, {8{wantBe[1]}}, {8{wantBe[0]}}};
						want = b << {ea[1:0], 3'b000};
						assert (!dMemCsn && !dMemWen && dMemBe == wantBe && dMemAddr == ea[13:2]
							&& (dMemDout & mask) == (want & mask))
						else reportMismatch($sformatf("store be %b data %h, expected be %b data %h",
							dMemBe, dMemDout, wantBe, want & mask));
					end
					opLoad: begin
						ea = a + {{20{ins[31]}}, ins[31:20]};
						want = dMemDi >> {ea[1:0], 3'b000};
						case (ins[14:12])
							3'd0: want = {{24{want[7]}}, want[7:0]};
							3'd1: want = {{16{want[15]}}, want[15:0]};
							3'd4: want = {24'b0, want[7:0]};
							3'd5: want = {16'b0, want[15:0]};
							default: ;
						endcase
						assert (rfWe && !dMemCsn && dMemWen && dMemAddr == ea[13:2] && rfWd == want)
						else reportMismatch($sformatf("load %h data %h, expected %h",
							ins, rfWd, want));
					end
					default: ;
				endcase
			end
		end
	end

	initial begin
		RSTn = 1'b1;
		lcgState = 32'd70;
		progLen = 0;
		progReady = 1'b0;
		haltSeen = 1'b0;
		expPc = '0;
		retired = '0;
		buildProgram();
		progReady = 1'b1;
		repeat (resetCycles) @(posedge CLK);
		RSTn <= 1'b0;
		wait (haltSeen);
		repeat (4) @(posedge CLK); // hold checked on the falling edges in between
		$display("ALL CHECKS PASSED");
		$finish;
	end

	// straight-line program, twice its length is plenty
	initial begin
		wait (progReady);
		repeat (2 * progLen + resetCycles) @(posedge CLK);
		$display("watchdog expired before the core halted");
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire
